// File: logic/fetch_pkg.sv
// types shared by the fetch side of the core
package fetch_pkg;

    // instruction address
    typedef logic [31:0] pc_t;

    // raw instruction word as returned by memory
    typedef logic [31:0] inst_t;

    // word fetch, so the pc moves one word per accepted address
    localparam pc_t PC_STEP = 32'd4;

    // address channel FSM
    // refill is the first request after the pc queue drained a slot
    typedef enum logic [1:0] {
        ADDR_IDLE                = 2'b00,
        ADDR_WAIT_ARREADY        = 2'b01,
        ADDR_WAIT_ROOM           = 2'b11,
        ADDR_REFILL_WAIT_ARREADY = 2'b10
    } addr_state_e;

endpackage

// File: logic/mem_rd_pkg.sv
// read port of the instruction memory
package mem_rd_pkg;

    // read response code, same width as the bus
    typedef logic [2:0] resp_t;

    // only okay responses are expected
    localparam resp_t RESP_OKAY = 3'd0;

endpackage

// File: logic/fetch_fifo.sv
`timescale 1ns/10ps

module fetch_fifo #(
    parameter int WIDTH      = 32,
    parameter int FIFO_DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flush,
    input  logic             push,
    input  logic             pop,
    input  logic [WIDTH-1:0] wdata,
    output logic [WIDTH-1:0] rdata,
    output logic             full,
    output logic             empty
);

    // address bits, depth is a power of two
    localparam int AW = $clog2(FIFO_DEPTH);

    logic [WIDTH-1:0] mem [FIFO_DEPTH];
    // extra msb tells full from empty
    logic [AW:0]      wr_ptr;
    logic [AW:0]      rd_ptr;
    logic             wr_en;

    // flush drops a push in the same cycle
    assign wr_en = push && !flush;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // head entry, valid while not empty
    assign rdata = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= wdata;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> !full)
        else $error("push into full fifo");

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty)
        else $error("pop from empty fifo");

endmodule

// File: logic/fetch_addr_ctrl.sv
`timescale 1ns/10ps

module fetch_addr_ctrl
    import fetch_pkg::*;
#(
    parameter pc_t RST_PC = 32'h8000_0000
) (
    input  logic clk,
    input  logic rst_n,
    // redirect from execute
    input  logic flush,
    input  pc_t  jump_pc,
    // pc queue state
    input  logic pc_full,
    input  logic issue_pop,
    // read address channel
    input  logic arready,
    output logic arvalid,
    output pc_t  raddr,
    output logic ar_fire
);

    addr_state_e state;
    addr_state_e state_nxt;
    logic        ar_req;

    // states in which an address is offered
    assign ar_req = (state == ADDR_WAIT_ARREADY) || (state == ADDR_REFILL_WAIT_ARREADY);

    // pc queue full means every slot already has a read in flight
    // so the request is held back until a slot drains
    assign arvalid = ar_req && !pc_full;

    // address accepted, also the push of the pc queue
    assign ar_fire = arvalid && arready;

    always_comb begin
        state_nxt = state;
        case (state)
            // leave reset, first request next cycle
            ADDR_IDLE: begin
                state_nxt = ADDR_WAIT_ARREADY;
            end
            ADDR_WAIT_ARREADY, ADDR_REFILL_WAIT_ARREADY: begin
                // queue filled by the last accept and nothing drains
                if (pc_full && !issue_pop && !flush) begin
                    state_nxt = ADDR_WAIT_ROOM;
                end else if (ar_fire) begin
                    state_nxt = ADDR_WAIT_ARREADY;
                end
            end
            // wait for decode to take an entry
            // a flush empties the queue, which also frees room
            ADDR_WAIT_ROOM: begin
                if (issue_pop || flush) begin
                    state_nxt = ADDR_REFILL_WAIT_ARREADY;
                end
            end
            default: begin
                state_nxt = ADDR_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ADDR_IDLE;
            raddr <= RST_PC;
        end else begin
            state <= state_nxt;
            // redirect wins over the sequential step
            // an address taken in the flush cycle belongs to the old stream
            if (flush) begin
                raddr <= jump_pc;
            end else if (ar_fire) begin
                raddr <= raddr + PC_STEP;
            end
        end
    end

    // offered address stays put until taken, unless fetch is redirected
    property p_raddr_hold;
        @(posedge clk) disable iff (!rst_n)
        arvalid && !arready && !flush |=> arvalid && $stable(raddr);
    endproperty

    a_raddr_hold: assert property (p_raddr_hold)
        else $error("raddr or arvalid changed before the address was accepted");

    // waiting for room only while the pc queue really is full
    property p_room_wait_full;
        @(posedge clk) disable iff (!rst_n)
        (state == ADDR_WAIT_ROOM) |-> pc_full;
    endproperty

    a_room_wait_full: assert property (p_room_wait_full)
        else $error("address FSM waits for room but pc queue is not full");

endmodule

// File: logic/fetch_drop_ctrl.sv
`timescale 1ns/10ps

module fetch_drop_ctrl
    import mem_rd_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  flush,
    input  logic  ar_fire,
    input  logic  rvalid,
    input  resp_t rresp,
    output logic  resp_keep
);

    // counts 0 to FIFO_DEPTH inclusive
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    logic [CW-1:0] out_cnt;
    logic [CW-1:0] out_nxt;
    logic [CW-1:0] drop_cnt;

    // reads accepted but not answered after this edge
    // rready is tied high, so rvalid alone retires one
    assign out_nxt = out_cnt + CW'(ar_fire) - CW'(rvalid);

    // response of the live stream only while nothing is left to drop
    assign resp_keep = rvalid && (drop_cnt == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_cnt  <= '0;
            drop_cnt <= '0;
        end else begin
            out_cnt <= out_nxt;
            // everything still in flight after a flush is stale
            // including an address taken in the flush cycle
            if (flush) begin
                drop_cnt <= out_nxt;
            end else if (rvalid && (drop_cnt != '0)) begin
                drop_cnt <= drop_cnt - CW'(1);
            end
        end
    end

    a_resp_okay: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid |-> (rresp == RESP_OKAY))
        else $error("non-okay read response 0x%0h", rresp);

    a_out_bound: assert property (@(posedge clk) disable iff (!rst_n)
        out_cnt <= CW'(FIFO_DEPTH))
        else $error("outstanding reads %0d above fifo depth", out_cnt);

endmodule

// File: logic/fetch_issue_reg.sv
`timescale 1ns/10ps

module fetch_issue_reg
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  flush,
    input  logic  inst_enable,
    // heads of the two queues
    input  logic  pc_empty,
    input  logic  inst_empty,
    input  pc_t   pc_head,
    input  inst_t inst_head,
    output logic  issue_pop,
    // decode side
    output logic  inst_valid,
    output pc_t   inst_pc,
    output inst_t inst
);

    // both heads leave together so a pc stays with its own word
    assign issue_pop = !flush && inst_enable && !pc_empty && !inst_empty;

    // valid bit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inst_valid <= 1'b0;
        end else if (flush) begin
            inst_valid <= 1'b0;
        end else if (inst_enable) begin
            // bubble when either queue is still empty
            inst_valid <= issue_pop;
        end
    end

    // payload, held while decode is stalled
    always_ff @(posedge clk) begin
        if (issue_pop) begin
            inst_pc <= pc_head;
            inst    <= inst_head;
        end
    end

endmodule

// File: logic/ifu_top.sv
`timescale 1ns/10ps

module ifu_top
    import fetch_pkg::*;
    import mem_rd_pkg::*;
#(
    parameter pc_t RST_PC     = 32'h8000_0000,
    parameter int  FIFO_DEPTH = 4
) (
    input  logic  clk,
    input  logic  rst_n,
    // redirect from execute
    input  logic  flush,
    input  pc_t   jump_pc,
    // read address channel
    input  logic  arready,
    output logic  arvalid,
    output pc_t   raddr,
    // read data channel
    input  logic  rvalid,
    input  inst_t rdata,
    input  resp_t rresp,
    output logic  rready,
    // decode side
    input  logic  inst_enable,
    output logic  inst_valid,
    output pc_t   inst_pc,
    output inst_t inst
);

    logic  ar_fire;
    logic  resp_keep;
    logic  issue_pop;
    logic  pc_full;
    logic  pc_empty;
    logic  inst_empty;
    pc_t   pc_head;
    inst_t inst_head;

    // responses are always taken
    assign rready = 1'b1;

    fetch_addr_ctrl #(
        .RST_PC (RST_PC)
    ) i_addr_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .jump_pc   (jump_pc),
        .pc_full   (pc_full),
        .issue_pop (issue_pop),
        .arready   (arready),
        .arvalid   (arvalid),
        .raddr     (raddr),
        .ar_fire   (ar_fire)
    );

    // pcs of accepted addresses, in issue order
    fetch_fifo #(
        .WIDTH      ($bits(pc_t)),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) pc_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (flush),
        .push  (ar_fire),
        .pop   (issue_pop),
        .wdata (raddr),
        .rdata (pc_head),
        .full  (pc_full),
        .empty (pc_empty)
    );

    fetch_drop_ctrl #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_drop_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .ar_fire   (ar_fire),
        .rvalid    (rvalid),
        .rresp     (rresp),
        .resp_keep (resp_keep)
    );

    // never fuller than the pc queue, so its full flag is not needed
    fetch_fifo #(
        .WIDTH      ($bits(inst_t)),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) inst_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (flush),
        .push  (resp_keep),
        .pop   (issue_pop),
        .wdata (rdata),
        .rdata (inst_head),
        .full  (),
        .empty (inst_empty)
    );

    fetch_issue_reg i_issue_reg (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .inst_enable (inst_enable),
        .pc_empty    (pc_empty),
        .inst_empty  (inst_empty),
        .pc_head     (pc_head),
        .inst_head   (inst_head),
        .issue_pop   (issue_pop),
        .inst_valid  (inst_valid),
        .inst_pc     (inst_pc),
        .inst        (inst)
    );

endmodule

// File: test/tb_ifu.sv
`timescale 1ns/10ps

module tb_ifu
    import fetch_pkg::*;
    import mem_rd_pkg::*;
();

    localparam pc_t   RST_PC      = 32'h8000_0000;
    localparam int    FIFO_DEPTH  = 4;
    localparam int    CLK_PERIOD  = 20;
    localparam int    MAX_LINES   = 100;
    // cycle budget per trace line and bound on every wait
    localparam int    LINE_CYCLES = 200;
    localparam inst_t INST_MASK   = 32'hA5A5_0000;
    localparam int    CMD_RUN     = 1;
    localparam int    CMD_FLUSH   = 2;
    localparam int    CMD_EXPECT  = 3;

    logic  clk = 1'b0;
    logic  rst_n;
    logic  flush;
    pc_t   jump_pc;
    logic  arready;
    logic  arvalid;
    pc_t   raddr;
    logic  rvalid = 1'b0;
    inst_t rdata  = '0;
    resp_t rresp  = RESP_OKAY;
    logic  rready;
    logic  inst_enable;
    logic  inst_valid;
    pc_t   inst_pc;
    inst_t inst;

    // five words per trace line
    logic [31:0] trace [0:511];
    int    trace_len   = 0;
    logic  trace_ready = 1'b0;
    int    err_cnt     = 0;
    int    tests_ok    = 0;
    int    tests_bad   = 0;

    // reference model of the decode stream and the address stream
    pc_t   next_pc;
    pc_t   next_addr;
    logic  hold_chk = 1'b0;
    logic  prev_valid;
    pc_t   prev_pc;
    inst_t prev_inst;

    // read slave state
    pc_t   rsp_addr [$];
    int    rsp_due [$];
    int    cyc = 0;
    int    due;

    always #(CLK_PERIOD / 2) clk = ~clk;

    ifu_top #(
        .RST_PC     (RST_PC),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_ifu_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .jump_pc     (jump_pc),
        .arready     (arready),
        .arvalid     (arvalid),
        .raddr       (raddr),
        .rvalid      (rvalid),
        .rdata       (rdata),
        .rresp       (rresp),
        .rready      (rready),
        .inst_enable (inst_enable),
        .inst_valid  (inst_valid),
        .inst_pc     (inst_pc),
        .inst        (inst)
    );

    function automatic logic [31:0] field(input int line, input int col);
        logic [8:0] idx;
        idx = 9'(line * 5 + col);
        return trace[idx];
    endfunction

    task automatic check_hex(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("ERR %s expected 0x%08h got 0x%08h", name, exp, act);
            err_cnt = err_cnt + 1;
        end
    endtask

    task automatic check_true(input logic ok, input string what);
        assert (ok) else begin
            $display("%s", what);
            err_cnt = err_cnt + 1;
        end
    endtask

    // in-order read slave answering 1 to 3 cycles after the address
    always @(posedge clk) begin
        if (rst_n) begin
            // rready is tied high so a response leaves on any rvalid edge
            if (rvalid) begin
                void'(rsp_addr.pop_front());
                void'(rsp_due.pop_front());
            end
            if (arvalid && arready) begin
                due = cyc + 1 + int'($urandom % 3);
                if (rsp_due.size() > 0 && due < rsp_due[$]) begin
                    due = rsp_due[$];
                end
                rsp_addr.push_back(raddr);
                rsp_due.push_back(due);
            end
        end
        cyc = cyc + 1;
        #2;
        if (rsp_addr.size() > 0 && rsp_due[0] <= cyc) begin
            rvalid = 1'b1;
            rdata  = rsp_addr[0] ^ INST_MASK;
        end else begin
            rvalid = 1'b0;
        end
    end

    // edge checker sampling everything before the DUT updates
    always @(posedge clk) begin
        if (rst_n) begin
            // responses are always taken
            check_hex("rready", 32'd1, 32'(rready));
            // stalled decode keeps the issue register frozen
            if (hold_chk) begin
                check_hex("inst_valid", 32'(prev_valid), 32'(inst_valid));
                check_hex("inst_pc", prev_pc, inst_pc);
                check_hex("inst", prev_inst, inst);
            end
            // address in the flush cycle belongs to the dead stream
            if (arvalid && arready && !flush) begin
                check_hex("raddr", next_addr, raddr);
                check_true((raddr - next_pc) <= PC_STEP * FIFO_DEPTH,
                    $sformatf("address 0x%08h accepted more than %0d reads ahead of decode",
                              raddr, FIFO_DEPTH));
                next_addr = next_addr + PC_STEP;
            end
            if (flush) begin
                next_pc   = jump_pc;
                next_addr = jump_pc;
            end else if (inst_valid && inst_enable) begin
                check_hex("inst_pc", next_pc, inst_pc);
                check_hex("inst", next_pc ^ INST_MASK, inst);
                next_pc = next_pc + PC_STEP;
            end
            hold_chk   = !inst_enable && !flush;
            prev_valid = inst_valid;
            prev_pc    = inst_pc;
            prev_inst  = inst;
        end
    end

    // called 2 ns after an edge and returns 2 ns after the next one
    task automatic drive_cycle(input logic en, input logic fl, input pc_t jpc, input logic hold_ar);
        inst_enable = en;
        flush       = fl;
        jump_pc     = jpc;
        // arready low one cycle in four unless forced
        arready     = hold_ar || (($urandom % 4) != 0);
        @(posedge clk);
        #2;
    endtask

    // random enable and then decode on until target is the next pc
    task automatic run_line(input int cycles, input int duty, input pc_t target);
        int waited;
        waited = 0;
        repeat (cycles) begin
            drive_cycle(($urandom % 100) < duty, 1'b0, '0, 1'b0);
        end
        while (next_pc != target && waited < LINE_CYCLES) begin
            drive_cycle(1'b1, 1'b0, '0, 1'b0);
            waited = waited + 1;
        end
        check_true(next_pc == target, $sformatf("decode never reached pc 0x%08h, next is 0x%08h",
                   target, next_pc));
    endtask

    // align puts the flush on a cycle with an accepted address
    task automatic flush_line(input int gap, input int align, input pc_t target);
        int waited;
        waited = 0;
        repeat (gap) begin
            drive_cycle(1'b1, 1'b0, '0, 1'b0);
        end
        while (align != 0 && !arvalid && waited < LINE_CYCLES) begin
            drive_cycle(1'b1, 1'b0, '0, 1'b0);
            waited = waited + 1;
        end
        check_true(align == 0 || arvalid, "arvalid never rose for a flush on an accepted address");
        drive_cycle(1'b1, 1'b1, target, align != 0);
        check_hex("inst_valid", 32'd0, 32'(inst_valid));
        // fetch restarts at the jump target
        check_hex("raddr", target, raddr);
    endtask

    // decode held off so nothing may leave the issue register
    task automatic expect_line(input int cycles, input pc_t target);
        repeat (cycles) begin
            drive_cycle(1'b0, 1'b0, '0, 1'b0);
        end
        // pc queue full, no further address offered
        if (next_addr - next_pc == PC_STEP * (FIFO_DEPTH + int'(inst_valid))) begin
            check_hex("arvalid", 32'd0, 32'(arvalid));
        end
        // a held instruction is the next one in order
        if (inst_valid) begin
            check_hex("inst_pc", target, inst_pc);
        end
    endtask

    task automatic close_test(input int id, input int errs_before);
        if (err_cnt == errs_before) begin
            tests_ok = tests_ok + 1;
            $display("test %0d: ok", id);
        end else begin
            tests_bad = tests_bad + 1;
            $display("test %0d: %0d failed checks", id, err_cnt - errs_before);
        end
    endtask

    initial begin
        int  cur;
        int  base;
        int  cmd;
        pc_t pc;
        void'($urandom(99037));
        rst_n       = 1'b0;
        flush       = 1'b0;
        jump_pc     = '0;
        arready     = 1'b0;
        inst_enable = 1'b0;
        next_pc     = RST_PC;
        next_addr   = RST_PC;
        $readmemh("test/fetch_trace.txt", trace);
        while (trace_len < MAX_LINES && field(trace_len, 0) != 0) begin
            trace_len = trace_len + 1;
        end
        trace_ready = 1'b1;
        check_true(trace_len > 0, "trace file holds no lines");
        // test 0 is reset with no request and no output
        cur  = 0;
        base = err_cnt;
        repeat (16) begin
            @(posedge clk);
            check_hex("arvalid", 32'd0, 32'(arvalid));
            check_hex("inst_valid", 32'd0, 32'(inst_valid));
        end
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        check_hex("arvalid", 32'd0, 32'(arvalid));
        check_hex("inst_valid", 32'd0, 32'(inst_valid));
        #2;
        for (int i = 0; i < trace_len; i++) begin
            if (int'(field(i, 0)) != cur) begin
                close_test(cur, base);
                cur  = int'(field(i, 0));
                base = err_cnt;
            end
            cmd = int'(field(i, 1));
            pc  = field(i, 4);
            case (cmd)
                CMD_RUN:    run_line(int'(field(i, 2)), int'(field(i, 3)), pc);
                CMD_FLUSH:  flush_line(int'(field(i, 2)), int'(field(i, 3)), pc);
                CMD_EXPECT: expect_line(int'(field(i, 2)), pc);
                default:    check_true(1'b0, $sformatf("unknown command %0d on trace line %0d",
                                       cmd, i + 1));
            endcase
        end
        close_test(cur, base);
        $display("tests: %0d passed, %0d failed, %0d failed checks", tests_ok, tests_bad, err_cnt);
        if (err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // budget grows with the trace length
    initial begin
        wait (trace_ready);
        #(trace_len * LINE_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles", trace_len * LINE_CYCLES);
        $display("sim failed");
        $finish;
    end

endmodule

// File: filelist.f
logic/fetch_pkg.sv
logic/mem_rd_pkg.sv
logic/fetch_fifo.sv
logic/fetch_addr_ctrl.sv
logic/fetch_drop_ctrl.sv
logic/fetch_issue_reg.sv
logic/ifu_top.sv
test/tb_ifu.sv

// File: Makefile
# Verilator build and run of the instruction fetch unit testbench

VERILATOR ?= verilator
TOP       ?= tb_ifu
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= sim passed

SIM_BIN  = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: test/fetch_trace.txt
// test, cmd (1 run, 2 flush, 3 expect), cycles, duty % or flush align, next decode pc
// all fields hex, a test number of 00 ends the trace
// sequential fetch from the reset pc
01 1 0020 64 800000c0
01 1 0008 64 80000100
// random decode enable
02 1 0028 32 800001a0
02 1 0030 0a 80000220
// decode held off, queues fill, then resume in order
03 3 001e 00 80000220
03 1 0000 64 80000240
03 1 0010 19 80000280
03 3 0014 00 80000280
03 1 0000 64 800002a0
// redirect with responses in flight
04 2 0003 00 90001000
04 1 0000 64 90001040
04 3 000a 00 90001040
04 2 0000 00 a0000200
04 1 0008 64 a0000240
// flushes close together, some on an accepted address
05 2 0001 00 b0000000
05 2 0001 01 c0000100
05 1 0000 64 c0000140
05 2 0000 01 d0000000
05 2 0002 00 e0000010
05 1 0010 4b e0000090
// long random mix
06 1 0040 50 e00001d0
00 0 0000 00 00000000
